// File: Makefile
TOP = tb_adc_oversample

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: design/adc_oversample_top.sv
`default_nettype none

module adc_oversample_top import adc_pkg::*; #(
	parameter int W_DATA         = 18,
	parameter int N_ADC          = 8,
	parameter int MAX_RATIO_LOG2 = 4
) (
	input  logic              data_valid_rdc,	// system clock
	input  logic              reset_in,
	// adc controller, asynchronous
	input  logic [N_ADC-1:0]  adc_valid,
	input  logic [W_DATA-1:0] adc_data_a,
	input  logic [W_DATA-1:0] adc_data_b,
	// config port
	input  logic              cfg_write,
	input  cfg_addr_e         cfg_addr,
	input  cfg_word_u         cfg_data,
	// averaged results
	output logic              result_strobe,
	output logic [3:0]        result_channel,
	output logic [W_DATA-1:0] result_a,
	output logic [W_DATA-1:0] result_b
);

	//////////////////////////////
	// internal wiring
	//////////////////////////////

	logic [ratio_w-1:0] ratio_log2;
	logic [N_ADC-1:0]   enable_mask;
	logic               clear;

	sample_if #(.W_DATA(W_DATA), .N_ADC(N_ADC)) smp_bus ();

	adc_valid_sync #(.W_DATA(W_DATA), .N_ADC(N_ADC)) u_sync (
		.data_valid_rdc (data_valid_rdc),
		.reset_in       (reset_in),
		.adc_valid      (adc_valid),
		.adc_data_a     (adc_data_a),
		.adc_data_b     (adc_data_b),
		.smp            (smp_bus.source)
	);

	oversample_regs #(.N_ADC(N_ADC), .MAX_RATIO_LOG2(MAX_RATIO_LOG2)) u_regs (
		.data_valid_rdc (data_valid_rdc),
		.reset_in       (reset_in),
		.cfg_write      (cfg_write),
		.cfg_addr       (cfg_addr),
		.cfg_data       (cfg_data),
		.ratio_log2     (ratio_log2),
		.enable_mask    (enable_mask),
		.clear          (clear)
	);

	oversample_filter #(
		.W_DATA         (W_DATA),
		.N_ADC          (N_ADC),
		.MAX_RATIO_LOG2 (MAX_RATIO_LOG2)
	) u_filter (
		.data_valid_rdc (data_valid_rdc),
		.reset_in       (reset_in),
		.smp            (smp_bus.sink),
		.ratio_log2     (ratio_log2),
		.enable_mask    (enable_mask),
		.clear          (clear),
		.result_strobe  (result_strobe),
		.result_channel (result_channel),
		.result_a       (result_a),
		.result_b       (result_b)
	);

endmodule

`default_nettype wire

// File: design/adc_pkg.sv
`default_nettype none

package adc_pkg;

	//////////////////////////////
	// config widths
	//////////////////////////////

	localparam int cfg_w   = 16;	// config data word
	localparam int ratio_w = 4;	// ratio_log2 field

	// register address, one bit
	typedef enum logic [0:0] {
		cfg_ratio  = 1'b0,	// oversample ratio
		cfg_enable = 1'b1	// channel enable mask
	} cfg_addr_e;

	// ratio view of the config word
	typedef struct packed {
		logic [cfg_w-ratio_w-1:0] reserved;	// ignored on write
		logic [ratio_w-1:0]       ratio_log2;	// average over 2**ratio_log2
	} cfg_ratio_s;

	// one config word decoded two ways
	// register address picks the view
	typedef union packed {
		cfg_ratio_s       ratio;	// addr cfg_ratio
		logic [cfg_w-1:0] mask;	// addr cfg_enable, low N_ADC bits used
	} cfg_word_u;

endpackage

`default_nettype wire

// File: design/adc_valid_sync.sv
`default_nettype none

// sample bus from the sync stage to the filter
interface sample_if #(
	parameter int W_DATA = 18,
	parameter int N_ADC  = 8
);
	logic              strobe;	// one system cycle per adc event
	logic [N_ADC-1:0]  valid_vec;	// captured channel flags
	logic [W_DATA-1:0] data_a;	// converter a word
	logic [W_DATA-1:0] data_b;	// converter b word

	modport source (output strobe, output valid_vec, output data_a, output data_b);
	modport sink (input strobe, input valid_vec, input data_a, input data_b);
endinterface

module adc_valid_sync #(
	parameter int W_DATA = 18,
	parameter int N_ADC  = 8
) (
	input  logic              data_valid_rdc,	// system clock
	input  logic              reset_in,
	input  logic [N_ADC-1:0]  adc_valid,	// adc clock domain
	input  logic [W_DATA-1:0] adc_data_a,
	input  logic [W_DATA-1:0] adc_data_b,
	sample_if.source          smp
);

	//////////////////////////////
	// adc domain capture
	//////////////////////////////

	logic              adc_valid_or;	// any channel valid
	logic [N_ADC-1:0]  cap_valid;
	logic [W_DATA-1:0] cap_a;
	logic [W_DATA-1:0] cap_b;

	assign adc_valid_or = |adc_valid;

	// latch words on the rising edge of the or
	// held until the next adc event
	always_ff @(posedge adc_valid_or) begin
		cap_valid <= adc_valid;
		cap_a     <= adc_data_a;
		cap_b     <= adc_data_b;
	end

	//////////////////////////////
	// system clock side
	//////////////////////////////

	logic [1:0] sync_q;	// two flop synchronizer
	logic       sync_d;	// delayed copy for edge detect
	logic       strobe_q;

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			sync_q   <= 2'b00;
			sync_d   <= 1'b0;
			strobe_q <= 1'b0;
		end else begin
			sync_q   <= {sync_q[0], adc_valid_or};
			sync_d   <= sync_q[1];
			// rising edge only, one pulse however long valid stays high
			strobe_q <= sync_q[1] & ~sync_d;
		end
	end

	// captured words settle long before the strobe
	assign smp.strobe    = strobe_q;
	assign smp.valid_vec = cap_valid;
	assign smp.data_a    = cap_a;
	assign smp.data_b    = cap_b;

endmodule

`default_nettype wire

// File: design/oversample_filter.sv
`default_nettype none

module oversample_filter import adc_pkg::*; #(
	parameter int W_DATA         = 18,
	parameter int N_ADC          = 8,
	parameter int MAX_RATIO_LOG2 = 4
) (
	input  logic               data_valid_rdc,
	input  logic               reset_in,
	sample_if.sink             smp,
	input  logic [ratio_w-1:0] ratio_log2,
	input  logic [N_ADC-1:0]   enable_mask,
	input  logic               clear,
	output logic               result_strobe,
	output logic [3:0]         result_channel,
	output logic [W_DATA-1:0]  result_a,
	output logic [W_DATA-1:0]  result_b
);

	//////////////////////////////
	// sizes and state
	//////////////////////////////

	localparam int acc_w = W_DATA + MAX_RATIO_LOG2;	// room for 2**max samples
	localparam int cnt_w = MAX_RATIO_LOG2 + 1;	// counts up to 2**max
	localparam int idx_w = (N_ADC > 1) ? $clog2(N_ADC) : 1;

	logic [acc_w-1:0] acc_a [N_ADC];	// running sums per channel
	logic [acc_w-1:0] acc_b [N_ADC];
	logic [cnt_w-1:0] count [N_ADC];	// samples so far

	logic [idx_w-1:0] sel_idx;	// lowest flagged channel
	logic             sel_hit;	// any flag set
	logic             take;	// sample goes into an accumulator
	logic [acc_w-1:0] sum_a;
	logic [acc_w-1:0] sum_b;
	logic [cnt_w-1:0] next_count;
	logic [cnt_w-1:0] target;	// 2**ratio_log2
	logic             done;	// average complete

	//////////////////////////////
	// priority encoder
	//////////////////////////////

	// scan from the top so the lowest set bit wins
	always_comb begin
		sel_idx = '0;
		sel_hit = 1'b0;
		for (int i = N_ADC - 1; i >= 0; i--) begin
			if (smp.valid_vec[i]) begin
				sel_idx = idx_w'(i);
				sel_hit = 1'b1;
			end
		end
	end

	assign take       = smp.strobe & sel_hit & enable_mask[sel_idx];
	assign sum_a      = acc_a[sel_idx] + acc_w'(smp.data_a);
	assign sum_b      = acc_b[sel_idx] + acc_w'(smp.data_b);
	assign next_count = count[sel_idx] + cnt_w'(1);
	assign target     = cnt_w'(1) << ratio_log2;
	assign done       = (next_count == target);

	//////////////////////////////
	// accumulators
	//////////////////////////////

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			result_strobe <= 1'b0;
			for (int i = 0; i < N_ADC; i++) begin
				acc_a[i] <= '0;
				acc_b[i] <= '0;
				count[i] <= '0;
			end
		end else begin
			result_strobe <= 1'b0;	// single cycle
			if (clear) begin
				// config changed, drop every partial average
				for (int i = 0; i < N_ADC; i++) begin
					acc_a[i] <= '0;
					acc_b[i] <= '0;
					count[i] <= '0;
				end
			end else if (take) begin
				if (done) begin
					acc_a[sel_idx] <= '0;	// start next average
					acc_b[sel_idx] <= '0;
					count[sel_idx] <= '0;
					result_strobe  <= 1'b1;
				end else begin
					acc_a[sel_idx] <= sum_a;
					acc_b[sel_idx] <= sum_b;
					count[sel_idx] <= next_count;
				end
			end
		end
	end

	// result words, only meaningful with result_strobe
	always_ff @(posedge data_valid_rdc) begin
		if (take && done) begin
			result_channel <= 4'(sel_idx);
			result_a       <= W_DATA'(sum_a >> ratio_log2);	// truncating mean
			result_b       <= W_DATA'(sum_b >> ratio_log2);
		end
	end

endmodule

`default_nettype wire

// File: design/oversample_regs.sv
`default_nettype none

module oversample_regs import adc_pkg::*; #(
	parameter int N_ADC          = 8,
	parameter int MAX_RATIO_LOG2 = 4
) (
	input  logic               data_valid_rdc,
	input  logic               reset_in,
	input  logic               cfg_write,	// one cycle write strobe
	input  cfg_addr_e          cfg_addr,
	input  cfg_word_u          cfg_data,
	output logic [ratio_w-1:0] ratio_log2,
	output logic [N_ADC-1:0]   enable_mask,
	output logic               clear	// pulses with every write
);

	//////////////////////////////
	// ratio clamp
	//////////////////////////////

	localparam logic [ratio_w-1:0] max_ratio = ratio_w'(MAX_RATIO_LOG2);

	logic [ratio_w-1:0] wr_ratio;	// written ratio after clamp

	// accumulators are sized for max_ratio only
	assign wr_ratio = (cfg_data.ratio.ratio_log2 > max_ratio) ?
		max_ratio : cfg_data.ratio.ratio_log2;

	//////////////////////////////
	// registers
	//////////////////////////////

	always_ff @(posedge data_valid_rdc or posedge reset_in) begin
		if (reset_in) begin
			ratio_log2  <= '0;	// pass through
			enable_mask <= '1;	// all channels on
			clear       <= 1'b0;
		end else begin
			clear <= cfg_write;	// same cycle the new value shows
			if (cfg_write) begin
				case (cfg_addr)
					cfg_ratio:  ratio_log2  <= wr_ratio;
					cfg_enable: enable_mask <= cfg_data.mask[N_ADC-1:0];
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: sources.f
design/adc_pkg.sv
design/adc_valid_sync.sv
design/oversample_regs.sv
design/oversample_filter.sv
design/adc_oversample_top.sv
testbench/adc_oversample_checker.sv
testbench/adc_oversample_assert.sv
testbench/tb_adc_oversample.sv

// File: testbench/adc_oversample_assert.sv
`default_nettype none

module adc_oversample_assert (
	input logic data_valid_rdc,
	input logic reset_in,
	input logic result_strobe,
	input logic smp_strobe	// sync stage output
);

	timeunit 1ns;
	timeprecision 1ps;

	// both strobes are single cycle pulses
	result_one_cycle: assert property (@(posedge data_valid_rdc) disable iff (reset_in)
		result_strobe |=> !result_strobe)
		else $error("result_strobe stayed high for two cycles");

	sample_one_cycle: assert property (@(posedge data_valid_rdc) disable iff (reset_in)
		smp_strobe |=> !smp_strobe)
		else $error("sample strobe fired in back to back cycles");

	result_quiet_in_reset: assert property (@(posedge data_valid_rdc)
		reset_in |-> !result_strobe)
		else $error("result_strobe high during reset");

endmodule

bind adc_oversample_top adc_oversample_assert strobe_rules (
	.data_valid_rdc (data_valid_rdc),
	.reset_in       (reset_in),
	.result_strobe  (result_strobe),
	.smp_strobe     (smp_bus.strobe)
);

`default_nettype wire

// File: testbench/adc_oversample_checker.sv
`default_nettype none

module adc_oversample_checker #(
	parameter int W_DATA = 18
) (
	input logic              data_valid_rdc,
	input logic              reset_in,
	input logic              result_strobe,
	input logic [3:0]        result_channel,
	input logic [W_DATA-1:0] result_a,
	input logic [W_DATA-1:0] result_b
);

	timeunit 1ns;
	timeprecision 1ps;

	// expected results, oldest first
	string             exp_name [$];
	logic [3:0]        exp_ch [$];
	logic [W_DATA-1:0] exp_a [$];
	logic [W_DATA-1:0] exp_b [$];

	int value_errors = 0;
	int unexpected   = 0;	// strobe with nothing queued
	int leftover     = 0;

	task automatic push_expect(string name, logic [3:0] ch, logic [W_DATA-1:0] a,
		logic [W_DATA-1:0] b);
		exp_name.push_back(name);
		exp_ch.push_back(ch);
		exp_a.push_back(a);
		exp_b.push_back(b);
	endtask

	function automatic int pending_count();
		return exp_ch.size();
	endfunction

	function automatic void compare_word(string name, string field, logic [W_DATA-1:0] exp,
		logic [W_DATA-1:0] act);
		if (exp !== act) begin
			$display("ERROR %s %s: expected %05h, actual %05h", name, field, exp, act);
			value_errors++;
		end
	endfunction

	task automatic report_leftover();
		if (exp_ch.size() > 0) begin
			$display("%0d expected results never arrived, first one from test %s",
				exp_ch.size(), exp_name[0]);
			leftover = exp_ch.size();
		end
	endtask

	// outputs move on the rising edge, look on the falling one
	always @(negedge data_valid_rdc) begin
		if (result_strobe === 1'b1 && reset_in) begin
			$display("result strobe fired while reset was held");
			unexpected++;
		end else if (result_strobe === 1'b1 && exp_ch.size() == 0) begin
			$display("result on channel %0d arrived with no expected result", result_channel);
			unexpected++;
		end else if (result_strobe === 1'b1) begin
			compare_word(exp_name[0], "channel", W_DATA'(exp_ch[0]), W_DATA'(result_channel));
			compare_word(exp_name[0], "result_a", exp_a[0], result_a);
			compare_word(exp_name[0], "result_b", exp_b[0], result_b);
			void'(exp_name.pop_front());
			void'(exp_ch.pop_front());
			void'(exp_a.pop_front());
			void'(exp_b.pop_front());
		end
	end

endmodule

`default_nettype wire

// File: testbench/adc_vectors.txt
# W addr data | S vec a b count | L vec a b high_cycles, all hex
# E chan a b test, put just before the event that completes it
E 0 00123 00456 pass_through
S 01 00123 00456 1
E 1 00010 00020 pass_through
S 0A 00010 00020 1
E 7 3FFFF 00001 pass_through
S 80 3FFFF 00001 1
# ratio 4, channels 3 and 0 interleaved
W 0 0002
S 08 00100 00010 1
S 01 00004 3FFFF 3
S 08 00101 00020 1
S 08 00102 00030 1
E 3 00101 00028 ratio_avg
S 08 00104 00041 1
E 0 00004 3FFFF ratio_avg
S 01 00004 3FFFF 1
# partial sums on channel 2 dropped by the write
S 04 00AAA 00BBB 2
W 0 0001
S 04 00010 00030 1
E 2 00011 00031 ratio_rewrite
S 04 00012 00032 1
# channel 5 masked then back on
W 0 0000
W 1 00DF
S 20 01111 02222 2
W 1 00FF
E 5 03333 04444 enable_mask
S 20 03333 04444 1
# channels 2 and 6 together count on 2 only
W 0 0001
S 44 00002 00004 1
S 40 00100 00200 1
E 2 00003 00005 multi_channel
S 04 00004 00006 1
E 6 00180 00280 multi_channel
S 40 00200 00300 1
# long valid pulse, then ratio 15 clamped to 4
W 0 0000
E 4 01234 05678 long_pulse
L 10 01234 05678 20
W 0 000F
S 02 00100 00200 F
E 1 00100 00200 ratio_clamp
S 02 00100 00200 1

// File: testbench/tb_adc_oversample.sv
`default_nettype none

module tb_adc_oversample import adc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int W_DATA = 18;
	localparam int N_ADC  = 8;

	logic              data_valid_rdc;
	logic              reset_in;
	logic [N_ADC-1:0]  adc_valid;
	logic [W_DATA-1:0] adc_data_a;
	logic [W_DATA-1:0] adc_data_b;
	logic              cfg_write;
	cfg_addr_e         cfg_addr;
	cfg_word_u         cfg_data;
	logic              result_strobe;
	logic [3:0]        result_channel;
	logic [W_DATA-1:0] result_a;
	logic [W_DATA-1:0] result_b;

	int timeouts    = 0;
	int file_errors = 0;	// missing file or bad line

	adc_oversample_top #(.W_DATA(W_DATA), .N_ADC(N_ADC), .MAX_RATIO_LOG2(4)) UUT (
		.data_valid_rdc (data_valid_rdc),
		.reset_in       (reset_in),
		.adc_valid      (adc_valid),
		.adc_data_a     (adc_data_a),
		.adc_data_b     (adc_data_b),
		.cfg_write      (cfg_write),
		.cfg_addr       (cfg_addr),
		.cfg_data       (cfg_data),
		.result_strobe  (result_strobe),
		.result_channel (result_channel),
		.result_a       (result_a),
		.result_b       (result_b)
	);

	adc_oversample_checker #(.W_DATA(W_DATA)) result_check (
		.data_valid_rdc (data_valid_rdc),
		.reset_in       (reset_in),
		.result_strobe  (result_strobe),
		.result_channel (result_channel),
		.result_a       (result_a),
		.result_b       (result_b)
	);

	// 100 ns system clock
	initial begin
		data_valid_rdc = 1'b0;
		forever #50 data_valid_rdc = ~data_valid_rdc;
	end

	// poll until every queued result came back
	task automatic wait_results();
		int n;
		n = 0;
		while (result_check.pending_count() > 0 && n < 50) begin
			@(posedge data_valid_rdc);
			n++;
		end
		if (result_check.pending_count() > 0) begin
			$display("timeout, an expected result did not arrive within 50 cycles");
			timeouts++;
		end
	endtask

	// one adc event, valid held for high cycles
	task automatic drive_adc(logic [N_ADC-1:0] vec, logic [W_DATA-1:0] a,
		logic [W_DATA-1:0] b, int high);
		int gap;
		@(posedge data_valid_rdc);
		#10;
		adc_data_a = a;
		adc_data_b = b;
		adc_valid  = vec;	// words already set when the or rises
		repeat (high) @(posedge data_valid_rdc);
		#10 adc_valid = '0;
		repeat (3) @(posedge data_valid_rdc);	// low time
		gap = 2 + int'($urandom % 4);	// idle 2 to 5
		repeat (gap) @(posedge data_valid_rdc);
		wait_results();
	endtask

	task automatic write_cfg(logic addr, logic [cfg_w-1:0] data);
		@(posedge data_valid_rdc);
		#10;
		cfg_write = 1'b1;
		cfg_addr  = cfg_addr_e'(addr);
		cfg_data  = data;
		@(posedge data_valid_rdc);
		#10 cfg_write = 1'b0;	// single cycle strobe
		repeat (2) @(posedge data_valid_rdc);
	endtask

	//////////////////////////////
	// vector file driver
	//////////////////////////////

	initial begin
		int          fd;
		int          n;
		int          total;
		string       line;
		string       kind;
		string       name;
		logic [31:0] f1, f2, f3, f4;
		void'($urandom(32'h46d));
		reset_in   = 1'b1;
		adc_valid  = '0;
		adc_data_a = '0;
		adc_data_b = '0;
		cfg_write  = 1'b0;
		cfg_addr   = cfg_ratio;
		cfg_data   = '0;
		// one adc event inside reset, nothing may come out of it
		repeat (4) @(posedge data_valid_rdc);
		#10;
		adc_data_a = 18'h2aaaa;
		adc_data_b = 18'h15555;
		adc_valid  = N_ADC'(1);	// channel 0
		repeat (3) @(posedge data_valid_rdc);
		#10 adc_valid = '0;
		repeat (9) @(posedge data_valid_rdc);
		#10 reset_in = 1'b0;
		fd = $fopen("testbench/adc_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/adc_vectors.txt");
			file_errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				n = $sscanf(line, "%s", kind);
				if (n < 1 || kind[0] == "#") continue;	// blank or comment
				case (kind)
					"W": begin
						n = $sscanf(line, "%s %h %h", kind, f1, f2);
						write_cfg(f1[0], f2[cfg_w-1:0]);
					end
					"E": begin
						n = $sscanf(line, "%s %h %h %h %s", kind, f1, f2, f3, name);
						result_check.push_expect(name, f1[3:0], f2[W_DATA-1:0], f3[W_DATA-1:0]);
					end
					"S": begin
						n = $sscanf(line, "%s %h %h %h %h", kind, f1, f2, f3, f4);
						for (int i = 0; i < int'(f4); i++) begin
							drive_adc(f1[N_ADC-1:0], f2[W_DATA-1:0], f3[W_DATA-1:0], 3);
						end
					end
					"L": begin
						n = $sscanf(line, "%s %h %h %h %h", kind, f1, f2, f3, f4);
						drive_adc(f1[N_ADC-1:0], f2[W_DATA-1:0], f3[W_DATA-1:0], int'(f4));
					end
					default: begin
						$display("unknown line kind %s in the vector file", kind);
						file_errors++;
					end
				endcase
			end
			$fclose(fd);
		end
		repeat (10) @(posedge data_valid_rdc);	// catch stray results
		result_check.report_leftover();
		total = result_check.value_errors + result_check.unexpected +
			result_check.leftover + timeouts + file_errors;
		$display("errors: %0d wrong value, %0d unexpected, %0d leftover, %0d timeout, %0d file",
			result_check.value_errors, result_check.unexpected, result_check.leftover,
			timeouts, file_errors);
		if (total == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
